/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Field positions of an RV32 I-type word
    localparam int opcode_lsb  = 0;
    localparam int opcode_msb  = 6;
    localparam int rd_lsb      = 7;
    localparam int rd_msb      = 11;
    localparam int funct3_lsb  = 12;
    localparam int funct3_msb  = 14;
    localparam int rs1_lsb     = 15;   // Also the uimm field of the immediate forms
    localparam int rs1_msb     = 19;
    localparam int funct12_lsb = 20;   // Also the CSR address
    localparam int funct12_msb = 31;

    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [2:0] f3_priv   = 3'b000;   // ECALL, EBREAK, MRET
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrs  = 3'b010;
    localparam logic [2:0] f3_csrrc  = 3'b011;
    localparam logic [2:0] f3_csrrwi = 3'b101;
    localparam logic [2:0] f3_csrrsi = 3'b110;
    localparam logic [2:0] f3_csrrci = 3'b111;

    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;
    localparam logic [11:0] f12_mret   = 12'h302;

endpackage

`default_nettype wire

/* source/rv_csr_pkg.sv */
`default_nettype none

package rv_csr_pkg;

    typedef enum logic [2:0] {
        op_none    = 3'd0,
        op_write   = 3'd1,
        op_set     = 3'd2,
        op_clear   = 3'd3,
        op_ecall   = 3'd4,
        op_ebreak  = 3'd5,
        op_mret    = 3'd6,
        op_illegal = 3'd7
    } csr_op_t;

    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t addr_mstatus    = 12'h300;
    localparam csr_addr_t addr_misa       = 12'h301;
    localparam csr_addr_t addr_mie        = 12'h304;
    localparam csr_addr_t addr_mtvec      = 12'h305;
    localparam csr_addr_t addr_mcounteren = 12'h306;
    localparam csr_addr_t addr_mstatush   = 12'h310;
    localparam csr_addr_t addr_mscratch   = 12'h340;
    localparam csr_addr_t addr_mepc       = 12'h341;
    localparam csr_addr_t addr_mcause     = 12'h342;
    localparam csr_addr_t addr_mip        = 12'h344;

    localparam logic [3:0] cause_illegal    = 4'd2;
    localparam logic [3:0] cause_breakpoint = 4'd3;
    localparam logic [3:0] cause_ecall_m    = 4'd11;
    localparam logic [3:0] cause_timer      = 4'd7;    // Interrupt causes
    localparam logic [3:0] cause_external   = 4'd11;

    localparam logic ext_c      = 1'b1;
    localparam logic ext_m      = 1'b1;
    localparam logic ext_zicntr = 1'b1;

    // MXL=1 and the I bit, plus the optional M and C bits
    localparam logic [31:0] misa_value = 32'h4000_0100 | (32'(ext_m) << 12) | (32'(ext_c) << 2);

    localparam logic [1:0] mtvec_direct   = 2'b00;
    localparam logic [1:0] mtvec_vectored = 2'b01;

    typedef union packed {
        logic [31:0] raw;      // CSR access view
        struct packed {
            logic [29:0] base;
            logic [1:0]  mode;
        } fields;              // Redirect view
    } mtvec_t;

endpackage

`default_nettype wire

/* source/rv_csr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rv_csr_if;

    logic                    valid;
    rv_csr_pkg::csr_op_t     op;
    rv_csr_pkg::csr_addr_t   addr;
    logic [31:0]             operand;    // rs1 value or zero-extended uimm
    logic                    write_en;   // Low for set/clear with a zero source
    logic                    rd_en;      // Destination is not x0
    logic [31:0]             pc;

    modport stage_out (
        output valid,
        output op,
        output addr,
        output operand,
        output write_en,
        output rd_en,
        output pc
    );

    modport stage_in (
        input valid,
        input op,
        input addr,
        input operand,
        input write_en,
        input rd_en,
        input pc
    );

endinterface

`default_nettype wire

/* source/rv_csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr_decode
(
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    input  wire                 i_valid,
    input  wire [31:0]          i_instr,
    input  wire [31:0]          i_pc,
    input  wire [31:0]          i_rs1_data,
    rv_csr_if.stage_out         o_stage
);

    logic [6:0]              opcode;
    logic [4:0]              rd_idx;
    logic [2:0]              funct3;
    logic [4:0]              rs1_idx;
    logic [11:0]             funct12;
    rv_csr_pkg::csr_op_t     op_next;
    logic [31:0]             operand_next;
    logic                    write_en_next;

    assign opcode  = i_instr[rv_isa_pkg::opcode_msb:rv_isa_pkg::opcode_lsb];
    assign rd_idx  = i_instr[rv_isa_pkg::rd_msb:rv_isa_pkg::rd_lsb];
    assign funct3  = i_instr[rv_isa_pkg::funct3_msb:rv_isa_pkg::funct3_lsb];
    assign rs1_idx = i_instr[rv_isa_pkg::rs1_msb:rv_isa_pkg::rs1_lsb];
    assign funct12 = i_instr[rv_isa_pkg::funct12_msb:rv_isa_pkg::funct12_lsb];

    always_comb
    begin
        op_next = rv_csr_pkg::op_illegal;        // Anything outside SYSTEM
        if (opcode == rv_isa_pkg::opcode_system)
        begin
            case (funct3)
                rv_isa_pkg::f3_csrrw,
                rv_isa_pkg::f3_csrrwi: op_next = rv_csr_pkg::op_write;
                rv_isa_pkg::f3_csrrs,
                rv_isa_pkg::f3_csrrsi: op_next = rv_csr_pkg::op_set;
                rv_isa_pkg::f3_csrrc,
                rv_isa_pkg::f3_csrrci: op_next = rv_csr_pkg::op_clear;
                rv_isa_pkg::f3_priv:
                begin
                    case (funct12)
                        rv_isa_pkg::f12_ecall:  op_next = rv_csr_pkg::op_ecall;
                        rv_isa_pkg::f12_ebreak: op_next = rv_csr_pkg::op_ebreak;
                        rv_isa_pkg::f12_mret:   op_next = rv_csr_pkg::op_mret;
                        default:                op_next = rv_csr_pkg::op_illegal;
                    endcase
                end
                default: op_next = rv_csr_pkg::op_illegal;   // funct3 = 100
            endcase
        end
    end

    // funct3 bit 2 marks the immediate forms
    assign operand_next  = funct3[2] ? {27'b0, rs1_idx} : i_rs1_data;
    assign write_en_next = (op_next == rv_csr_pkg::op_write) || (rs1_idx != 5'd0);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            o_stage.valid <= 1'b0;
        else
            o_stage.valid <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        o_stage.op       <= i_valid ? op_next : rv_csr_pkg::op_none;
        o_stage.addr     <= funct12;             // CSR address field
        o_stage.operand  <= operand_next;
        o_stage.write_en <= write_en_next;
        o_stage.rd_en    <= (rd_idx != 5'd0);
        o_stage.pc       <= i_pc;
    end

    // The stage 2 handshake must be defined once reset is released
    a_valid_known: assert property (
        @(posedge i_clk) disable iff (!i_reset_n) !$isunknown(o_stage.valid)
    );

endmodule

`default_nettype wire

/* source/rv_csr_machine.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr_machine
(
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    rv_csr_if.stage_in          i_stage,
    input  wire [31:0]          i_next_pc,
    input  wire                 i_int_timer,
    input  wire                 i_int_ext,
    output logic                o_rd_valid,
    output logic [31:0]         o_rd_data,
    output logic                o_redirect_valid,
    output logic [31:0]         o_redirect_pc
);

    logic sel_mstatus, sel_misa, sel_mie, sel_mtvec, sel_mcounteren;
    logic sel_mstatush, sel_mscratch, sel_mepc, sel_mcause, sel_mip;
    logic csr_known;
    logic csr_op;
    logic do_write;
    logic do_mret;
    logic trap_sync;
    logic take_int;
    logic trap_any;
    logic [3:0] sync_cause;
    logic [3:0] int_cause;
    logic [31:0] read_data;
    logic [31:0] new_value;
    logic [31:0] trap_target;

    logic status_mie_q, status_mpie_q;
    logic msie_q, mtie_q, meie_q;
    rv_csr_pkg::mtvec_t mtvec_q;
    logic [2:0] mcounteren_q;
    logic [31:0] mscratch_q;
    logic [31:1] mepc_q;
    logic mcause_int_q;
    logic [3:0] mcause_code_q;

    assign sel_mstatus    = (i_stage.addr == rv_csr_pkg::addr_mstatus);
    assign sel_misa       = (i_stage.addr == rv_csr_pkg::addr_misa);
    assign sel_mie        = (i_stage.addr == rv_csr_pkg::addr_mie);
    assign sel_mtvec      = (i_stage.addr == rv_csr_pkg::addr_mtvec);
    assign sel_mcounteren = (i_stage.addr == rv_csr_pkg::addr_mcounteren);
    assign sel_mstatush   = (i_stage.addr == rv_csr_pkg::addr_mstatush);
    assign sel_mscratch   = (i_stage.addr == rv_csr_pkg::addr_mscratch);
    assign sel_mepc       = (i_stage.addr == rv_csr_pkg::addr_mepc);
    assign sel_mcause     = (i_stage.addr == rv_csr_pkg::addr_mcause);
    assign sel_mip        = (i_stage.addr == rv_csr_pkg::addr_mip);

    assign csr_known = sel_mstatus | sel_misa | sel_mie | sel_mtvec | sel_mcounteren |
                       sel_mstatush | sel_mscratch | sel_mepc | sel_mcause | sel_mip;

    assign csr_op = (i_stage.op == rv_csr_pkg::op_write) ||
                    (i_stage.op == rv_csr_pkg::op_set) ||
                    (i_stage.op == rv_csr_pkg::op_clear);

    // misa, mstatush and mip read the same whatever is written
    assign read_data = ({32{sel_mstatus}}    & {24'b0, status_mpie_q, 3'b0, status_mie_q, 3'b0})
                     | ({32{sel_misa}}       & rv_csr_pkg::misa_value)
                     | ({32{sel_mie}}        & {20'b0, meie_q, 3'b0, mtie_q, 3'b0, msie_q, 3'b0})
                     | ({32{sel_mtvec}}      & mtvec_q.raw)
                     | ({32{sel_mcounteren}} & {29'b0, mcounteren_q})
                     | ({32{sel_mscratch}}   & mscratch_q)
                     | ({32{sel_mepc}}       & {mepc_q, 1'b0})
                     | ({32{sel_mcause}}     & {mcause_int_q, 27'b0, mcause_code_q})
                     | ({32{sel_mip}}        & {20'b0, i_int_ext, 3'b0, i_int_timer, 7'b0});

    always_comb
    begin
        case (i_stage.op)
            rv_csr_pkg::op_set:   new_value = read_data | i_stage.operand;
            rv_csr_pkg::op_clear: new_value = read_data & ~i_stage.operand;
            default:              new_value = i_stage.operand;
        endcase
    end

    assign do_write  = i_stage.valid && csr_op && csr_known && i_stage.write_en;
    assign do_mret   = i_stage.valid && (i_stage.op == rv_csr_pkg::op_mret);
    assign trap_sync = i_stage.valid && ((i_stage.op == rv_csr_pkg::op_ecall) ||
                                         (i_stage.op == rv_csr_pkg::op_ebreak) ||
                                         (i_stage.op == rv_csr_pkg::op_illegal) ||
                                         (csr_op && !csr_known));

    // Interrupts only slip into an empty stage 2 slot
    assign take_int = !i_stage.valid && status_mie_q &&
                      ((i_int_ext && meie_q) || (i_int_timer && mtie_q));
    assign trap_any = trap_sync || take_int;

    assign sync_cause = (i_stage.op == rv_csr_pkg::op_ecall)  ? rv_csr_pkg::cause_ecall_m :
                        (i_stage.op == rv_csr_pkg::op_ebreak) ? rv_csr_pkg::cause_breakpoint :
                                                                rv_csr_pkg::cause_illegal;
    assign int_cause  = (i_int_ext && meie_q) ? rv_csr_pkg::cause_external :
                                                rv_csr_pkg::cause_timer;

    always_comb
    begin
        case (mtvec_q.fields.mode)
            rv_csr_pkg::mtvec_direct:   trap_target = {mtvec_q.fields.base, 2'b00};
            rv_csr_pkg::mtvec_vectored: trap_target = {mtvec_q.fields.base, 2'b00} +
                                                      (take_int ? {26'b0, int_cause, 2'b00} : '0);
            default:                    trap_target = {mtvec_q.fields.base, 2'b00};
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            status_mie_q  <= 1'b0;
            status_mpie_q <= 1'b0;
        end
        else if (trap_any)
        begin
            status_mpie_q <= status_mie_q;
            status_mie_q  <= 1'b0;
        end
        else if (do_mret)
        begin
            status_mie_q  <= status_mpie_q;
            status_mpie_q <= 1'b1;
        end
        else if (do_write && sel_mstatus)
        begin
            status_mie_q  <= new_value[3];
            status_mpie_q <= new_value[7];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            msie_q <= 1'b0;
            mtie_q <= 1'b0;
            meie_q <= 1'b0;
            mtvec_q.raw <= '0;
            mcounteren_q <= '0;
        end
        else if (do_write)
        begin
            if (sel_mie)
            begin
                msie_q <= new_value[3];
                mtie_q <= new_value[7];
                meie_q <= new_value[11];
            end
            if (sel_mtvec)
                mtvec_q.raw <= new_value;
            if (sel_mcounteren)
                mcounteren_q <= new_value[2:0] & {3{rv_csr_pkg::ext_zicntr}};   // CY, TM, IR
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_write && sel_mscratch)
            mscratch_q <= new_value;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            mepc_q        <= '0;
            mcause_int_q  <= 1'b0;
            mcause_code_q <= '0;
        end
        else if (take_int)
        begin
            mepc_q        <= i_next_pc[31:1];    // Resume after the last retired instruction
            mcause_int_q  <= 1'b1;
            mcause_code_q <= int_cause;
        end
        else if (trap_sync)
        begin
            mepc_q        <= i_stage.pc[31:1];
            mcause_int_q  <= 1'b0;
            mcause_code_q <= sync_cause;
        end
        else if (do_write && sel_mepc)
            mepc_q <= new_value[31:1];
        else if (do_write && sel_mcause)
        begin
            mcause_int_q  <= new_value[31];
            mcause_code_q <= new_value[3:0];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_rd_valid       <= 1'b0;
            o_redirect_valid <= 1'b0;
        end
        else
        begin
            o_rd_valid       <= i_stage.valid && csr_op && csr_known && i_stage.rd_en;
            o_redirect_valid <= trap_any || do_mret;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_rd_data     <= read_data;          // Old CSR value
        o_redirect_pc <= do_mret ? {mepc_q, 1'b0} : trap_target;
    end

    a_one_result: assert property (
        @(posedge i_clk) disable iff (!i_reset_n) !(o_rd_valid && o_redirect_valid)
    );

endmodule

`default_nettype wire

/* source/rv_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr_unit
(
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    input  wire                 i_valid,
    input  wire [31:0]          i_instr,
    input  wire [31:0]          i_pc,
    input  wire [31:0]          i_rs1_data,
    input  wire [31:0]          i_next_pc,      // Return address for interrupts
    input  wire                 i_int_timer,
    input  wire                 i_int_ext,
    output wire                 o_rd_valid,
    output wire [31:0]          o_rd_data,
    output wire                 o_redirect_valid,
    output wire [31:0]          o_redirect_pc
);

    rv_csr_if stage_if ();     // Decode to CSR file

    rv_csr_decode decode_i
    (
        .i_clk                  (i_clk),
        .i_reset_n              (i_reset_n),
        .i_valid                (i_valid),
        .i_instr                (i_instr),
        .i_pc                   (i_pc),
        .i_rs1_data             (i_rs1_data),
        .o_stage                (stage_if.stage_out)
    );

    rv_csr_machine machine_i
    (
        .i_clk                  (i_clk),
        .i_reset_n              (i_reset_n),
        .i_stage                (stage_if.stage_in),
        .i_next_pc              (i_next_pc),
        .i_int_timer            (i_int_timer),
        .i_int_ext              (i_int_ext),
        .o_rd_valid             (o_rd_valid),
        .o_rd_data              (o_rd_data),
        .o_redirect_valid       (o_redirect_valid),
        .o_redirect_pc          (o_redirect_pc)
    );

endmodule

`default_nettype wire

/* testbench/rv_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_clk_gen
(
    output logic o_clk,
    output logic o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;     // 8 ns period
    end

    initial
    begin
        o_reset_n = 1'b0;
        repeat (4) @(posedge o_clk);
        #1 o_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/rv_csr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr_tb;

    logic        clk;
    logic        reset_n;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] next_pc;
    logic        int_timer;
    logic        int_ext;
    wire         rd_valid;
    wire  [31:0] rd_data;
    wire         redirect_valid;
    wire  [31:0] redirect_pc;

    string       step_kind[$];          // I for instruction, W for idle
    logic [31:0] step_a[$];
    logic [31:0] step_b[$];
    logic [31:0] step_c[$];
    logic [31:0] step_d[$];
    logic        step_timer[$];
    logic        step_ext[$];

    logic [31:0] exp_rd_q[$];
    logic [31:0] exp_redir_q[$];
    logic [31:0] got_rd_q[$];
    logic [31:0] got_redir_q[$];

    int value_errors = 0;
    int count_errors = 0;
    int file_errors  = 0;
    int total_cycles = 8;               // Reset plus drain
    int cycle_count  = 0;
    int cycle_limit  = 0;

    rv_clk_gen clk_gen_i
    (
        .o_clk      (clk),
        .o_reset_n  (reset_n)
    );

    rv_csr_unit dut_i
    (
        .i_clk              (clk),
        .i_reset_n          (reset_n),
        .i_valid            (valid),
        .i_instr            (instr),
        .i_pc               (pc),
        .i_rs1_data         (rs1_data),
        .i_next_pc          (next_pc),
        .i_int_timer        (int_timer),
        .i_int_ext          (int_ext),
        .o_rd_valid         (rd_valid),
        .o_rd_data          (rd_data),
        .o_redirect_valid   (redirect_valid),
        .o_redirect_pc      (redirect_pc)
    );

    task automatic read_trace();
        int fd;
        int n;
        int t;
        int e;
        string tok;
        string rest;
        logic [31:0] a, b, c, d;
        fd = $fopen("testbench/rv_csr_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file testbench/rv_csr_trace.txt");
            file_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            n = $fscanf(fd, " %s", tok);
            if (n != 1)
                break;
            if (tok.substr(0, 0) == "#")
                n = $fgets(rest, fd);           // Comment line
            else if (tok == "I" || tok == "W")
            begin
                if (tok == "I")
                    n = $fscanf(fd, " %h %h %h %h %d %d", a, b, c, d, t, e);
                else
                    n = $fscanf(fd, " %d %d %d", a, t, e);
                step_kind.push_back(tok);
                step_a.push_back(a);
                step_b.push_back(b);
                step_c.push_back(c);
                step_d.push_back(d);
                step_timer.push_back(t[0]);
                step_ext.push_back(e[0]);
                total_cycles += (tok == "I") ? 1 : int'(a);
            end
            else if (tok == "R" || tok == "J")
            begin
                n = $fscanf(fd, " %h", a);
                if (tok == "R")
                    exp_rd_q.push_back(a);
                else
                    exp_redir_q.push_back(a);
            end
            else
            begin
                $display("Unknown line kind '%s' in the trace file", tok);
                file_errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_instr(input logic [31:0] word, input logic [31:0] addr,
                               input logic [31:0] rs1, input logic [31:0] ret_pc,
                               input logic tmr, input logic ext);
        @(posedge clk);
        #1;
        valid     = 1'b1;
        instr     = word;
        pc        = addr;
        rs1_data  = rs1;
        next_pc   = ret_pc;
        int_timer = tmr;
        int_ext   = ext;
    endtask

    task automatic idle_cycles(input int n, input logic tmr, input logic ext);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            valid     = 1'b0;
            int_timer = tmr;
            int_ext   = ext;
        end
    endtask

    task automatic check_rd(input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED o_rd_data expected %08h actual %08h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_redirect(input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED o_redirect_pc expected %08h actual %08h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_results();
        while (exp_rd_q.size() > 0 && got_rd_q.size() > 0)
            check_rd(exp_rd_q.pop_front(), got_rd_q.pop_front());
        while (exp_redir_q.size() > 0 && got_redir_q.size() > 0)
            check_redirect(exp_redir_q.pop_front(), got_redir_q.pop_front());
        if (exp_rd_q.size() > 0)
            $display("%0d expected rd results never arrived", exp_rd_q.size());
        if (got_rd_q.size() > 0)
            $display("%0d rd results arrived that were not expected", got_rd_q.size());
        if (exp_redir_q.size() > 0)
            $display("%0d expected redirects never arrived", exp_redir_q.size());
        if (got_redir_q.size() > 0)
            $display("%0d redirects arrived that were not expected", got_redir_q.size());
        count_errors += exp_rd_q.size() + got_rd_q.size();
        count_errors += exp_redir_q.size() + got_redir_q.size();
    endtask

    // Results are captured mid-cycle where they are stable
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (rd_valid)
                got_rd_q.push_back(rd_data);
            if (redirect_valid)
                got_redir_q.push_back(redirect_pc);
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the trace did not finish", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial
    begin
        valid     = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_data  = '0;
        next_pc   = '0;
        int_timer = 1'b0;
        int_ext   = 1'b0;
        read_trace();
        cycle_limit = total_cycles + 50;
        wait (reset_n === 1'b1);
        for (int i = 0; i < step_kind.size(); i++)
        begin
            if (step_kind[i] == "I")
                drive_instr(step_a[i], step_b[i], step_c[i], step_d[i],
                            step_timer[i], step_ext[i]);
            else
                idle_cycles(int'(step_a[i]), step_timer[i], step_ext[i]);
        end
        idle_cycles(4, 1'b0, 1'b0);     // Let the last results drain
        @(negedge clk);
        compare_results();
        $display("Errors: %0d total, %0d value, %0d count, %0d trace file",
                 value_errors + count_errors + file_errors,
                 value_errors, count_errors, file_errors);
        if (value_errors + count_errors + file_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_csr.f */
source/rv_isa_pkg.sv
source/rv_csr_pkg.sv
source/rv_csr_if.sv
source/rv_csr_decode.sv
source/rv_csr_machine.sv
source/rv_csr_unit.sv
testbench/rv_clk_gen.sv
testbench/rv_csr_tb.sv

/* Makefile */
TOP = rv_csr_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f rv_csr.f --top-module $(TOP)

# The run passes only when the pass line shows up on stdout
sim:
	verilator --binary --timing --assert -f rv_csr.f --top-module $(TOP) -o rv_csr_sim
	@out="$$(./obj_dir/rv_csr_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* testbench/rv_csr_trace.txt */
# I instr pc rs1 next_pc timer ext | W cycles timer ext
# R expected rd value | J expected redirect pc
I 34011073 00001000 12345678 00001004 0 0
I 340110F3 00001004 A5A5A5A5 00001008 0 0
R 12345678
I 340120F3 00001008 0000FF00 0000100C 0 0
R A5A5A5A5
I 340130F3 0000100C A0000005 00001010 0 0
R A5A5FFA5
I 340020F3 00001010 FFFFFFFF 00001014 0 0
R 05A5FFA0
I 340020F3 00001014 00000000 00001018 0 0
R 05A5FFA0
I 3402D0F3 00001018 00000000 0000101C 0 0
R 05A5FFA0
I 340C60F3 0000101C 00000000 00001020 0 0
R 00000005
I 3401F0F3 00001020 00000000 00001024 0 0
R 0000001D
I 340020F3 00001024 00000000 00001028 0 0
R 0000001C
I 301110F3 00001028 00000000 0000102C 0 0
R 40001104
I 301020F3 0000102C 00000000 00001030 0 0
R 40001104
I 304110F3 00001030 FFFFFFFF 00001034 0 0
R 00000000
I 304020F3 00001034 00000000 00001038 0 0
R 00000888
I 304110F3 00001038 00000000 0000103C 0 0
R 00000888
I 341110F3 0000103C 00001003 00001040 0 0
R 00000000
I 341020F3 00001040 00000000 00001044 0 0
R 00001002
I 30511073 00001044 00000100 00001048 0 0
I 30046073 00001048 00000000 0000104C 0 0
I 00000073 00002000 00000000 00002004 0 0
J 00000100
I 341020F3 00000100 00000000 00000104 0 0
R 00002000
I 342020F3 00000104 00000000 00000108 0 0
R 0000000B
I 300020F3 00000108 00000000 0000010C 0 0
R 00000080
I 30200073 0000010C 00000000 00000110 0 0
J 00002000
I 300020F3 00002000 00000000 00002004 0 0
R 00000088
I 00100073 00002100 00000000 00002104 0 0
J 00000100
I 342020F3 00000100 00000000 00000104 0 0
R 00000003
I 341020F3 00000104 00000000 00000108 0 0
R 00002100
I 7C0110F3 00002200 00000001 00002204 0 0
J 00000100
I 342020F3 00000100 00000000 00000104 0 0
R 00000002
I 341020F3 00000104 00000000 00000108 0 0
R 00002200
I 300020F3 00000108 00000000 0000010C 0 0
R 00000000
I 30412073 00003000 00000080 00003004 0 0
I 30046073 00003000 00000000 00003004 0 0
W 6 1 0
J 00000100
I 342020F3 00000100 00000000 00000104 0 0
R 80000007
I 341020F3 00000104 00000000 00000108 0 0
R 00003004
I 30511073 00000108 00000101 0000010C 0 0
I 30412073 0000010C 00000800 00000110 0 0
I 30046073 00004000 00000000 00004004 0 0
W 6 1 1
J 0000012C
I 342020F3 0000012C 00000000 00000130 0 0
R 8000000B
I 341020F3 00000130 00000000 00000134 0 0
R 00004004
W 6 1 1
I 300020F3 00000134 00000000 00000138 0 0
R 00000080
